/* src/mul_pkg.sv */
`default_nettype none

package mul_pkg;

    // operand and product widths
    typedef logic [31:0] op_t;
    typedef logic [63:0] prod_t;

    // carry is already shifted to its weight
    typedef struct packed {
        prod_t sum;
        prod_t carry;
    } csa_pair_t;

    typedef struct packed {
        op_t  a;
        op_t  b;
        logic valid;
    } op_pair_t;

    // latch, compressor, three reduction stages, final adder
    localparam int MUL_LATENCY = 6;

    // one row of full adders, bit by bit
    function automatic csa_pair_t csa_row(
        input prod_t x,
        input prod_t y,
        input prod_t z
    );
        csa_pair_t r;
        r.sum   = x ^ y ^ z;
        r.carry = ((x & y) | (y & z) | (x & z)) << 1;
        return r;
    endfunction

endpackage

`default_nettype wire

/* src/mul_operand_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_operand_latch (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  mul_pkg::op_t      a,
    input  mul_pkg::op_t      b,
    output mul_pkg::op_pair_t op
);

    mul_pkg::op_t a_q;
    mul_pkg::op_t b_q;
    logic         valid_q;

    // one bit per operation in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start;
        end
    end

    // operands only move on start
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
        end
    end

    assign op = '{a: a_q, b: b_q, valid: valid_q};

endmodule

`default_nettype wire

/* src/pp_compress.sv */
`timescale 1ns/1ps
`default_nettype none

module pp_compress (
    input  logic                    clk,
    input  logic                    rst,
    input  mul_pkg::op_pair_t       op,
    output mul_pkg::csa_pair_t [15:0] pairs,
    output logic                    pairs_valid
);

    localparam int N_PP    = $bits(mul_pkg::op_t);
    localparam int N_PAIRS = N_PP / 2;

    mul_pkg::prod_t [N_PP-1:0]       pp;
    mul_pkg::csa_pair_t [N_PAIRS-1:0] pairs_d;

    always_comb begin
        // one shifted copy of a per set bit of b
        for (int i = 0; i < N_PP; i++) begin
            if (op.b[i]) begin
                pp[i] = mul_pkg::prod_t'(op.a) << i;
            end else begin
                pp[i] = '0;
            end
        end

        // neighbouring rows through a 3:2 layer with the third input tied low
        for (int k = 0; k < N_PAIRS; k++) begin
            pairs_d[k] = mul_pkg::csa_row(pp[2*k], pp[2*k+1], '0);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pairs_valid <= 1'b0;
        end else begin
            pairs_valid <= op.valid;
        end
    end

    // hold when no operation arrives
    always_ff @(posedge clk) begin
        if (op.valid) begin
            pairs <= pairs_d;
        end
    end

endmodule

`default_nettype wire

/* src/csa_reduce_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_reduce_stage #(
    parameter int N_PAIRS = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  mul_pkg::csa_pair_t [N_PAIRS-1:0]    in_pairs,
    input  logic                                in_valid,
    output mul_pkg::csa_pair_t [N_PAIRS/2-1:0]  out_pairs,
    output logic                                out_valid
);

    localparam int N_OUT = N_PAIRS / 2;

    mul_pkg::csa_pair_t [N_OUT-1:0] first_row;
    mul_pkg::csa_pair_t [N_OUT-1:0] out_d;

    // 4:2 compressor per output pair, made of two chained 3:2 rows
    always_comb begin
        for (int k = 0; k < N_OUT; k++) begin
            first_row[k] = mul_pkg::csa_row(
                in_pairs[2*k].sum,
                in_pairs[2*k+1].sum,
                in_pairs[2*k].carry
            );
            out_d[k] = mul_pkg::csa_row(
                first_row[k].sum,
                first_row[k].carry,
                in_pairs[2*k+1].carry
            );
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_pairs <= out_d;
        end
    end

endmodule

`default_nettype wire

/* src/final_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module final_adder (
    input  logic                      clk,
    input  logic                      rst,
    input  mul_pkg::csa_pair_t [1:0]  in_pairs,
    input  logic                      in_valid,
    output mul_pkg::prod_t            product,
    output logic                      done
);

    mul_pkg::prod_t sum_d;

    // carry-propagate sum of the last four vectors wrapping at 64 bits
    assign sum_d = in_pairs[0].sum + in_pairs[0].carry
                 + in_pairs[1].sum + in_pairs[1].carry;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            product <= '0;
            done    <= 1'b0;
        end else begin
            done <= in_valid;
            // product holds between pulses
            if (in_valid) begin
                product <= sum_d;
            end
        end
    end

endmodule

`default_nettype wire

/* src/wallace_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wallace_mul_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  mul_pkg::op_t   a,
    input  mul_pkg::op_t   b,
    output mul_pkg::prod_t product,
    output logic           done
);

    // pair count after each layer
    localparam int PAIRS_0 = 16;
    localparam int PAIRS_1 = PAIRS_0 / 2;
    localparam int PAIRS_2 = PAIRS_1 / 2;
    localparam int PAIRS_3 = PAIRS_2 / 2;

    mul_pkg::op_pair_t                op;
    mul_pkg::csa_pair_t [PAIRS_0-1:0] pairs_0;
    mul_pkg::csa_pair_t [PAIRS_1-1:0] pairs_1;
    mul_pkg::csa_pair_t [PAIRS_2-1:0] pairs_2;
    mul_pkg::csa_pair_t [PAIRS_3-1:0] pairs_3;
    logic                             valid_0;
    logic                             valid_1;
    logic                             valid_2;
    logic                             valid_3;

    mul_operand_latch i_mul_operand_latch (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .a     (a),
        .b     (b),
        .op    (op)
    );

    pp_compress i_pp_compress (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .pairs       (pairs_0),
        .pairs_valid (valid_0)
    );

    csa_reduce_stage #(.N_PAIRS(PAIRS_0)) i_reduce_16 (
        .clk       (clk),
        .rst       (rst),
        .in_pairs  (pairs_0),
        .in_valid  (valid_0),
        .out_pairs (pairs_1),
        .out_valid (valid_1)
    );

    csa_reduce_stage #(.N_PAIRS(PAIRS_1)) i_reduce_8 (
        .clk       (clk),
        .rst       (rst),
        .in_pairs  (pairs_1),
        .in_valid  (valid_1),
        .out_pairs (pairs_2),
        .out_valid (valid_2)
    );

    csa_reduce_stage #(.N_PAIRS(PAIRS_2)) i_reduce_4 (
        .clk       (clk),
        .rst       (rst),
        .in_pairs  (pairs_2),
        .in_valid  (valid_2),
        .out_pairs (pairs_3),
        .out_valid (valid_3)
    );

    final_adder i_final_adder (
        .clk      (clk),
        .rst      (rst),
        .in_pairs (pairs_3),
        .in_valid (valid_3),
        .product  (product),
        .done     (done)
    );

endmodule

`default_nettype wire

/* bench/mul_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_asserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic done
);

    localparam int LAT = mul_pkg::MUL_LATENCY;

    // every start gives one done, LAT edges later
    a_latency: assert property (@(posedge clk) disable iff (rst)
        done == $past(start, LAT))
        else $error("done does not follow start by %0d cycles", LAT);

    a_done_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(done))
        else $error("done is unknown after reset");

    a_done_in_reset: assert property (@(posedge clk)
        rst |-> !done)
        else $error("done is high during reset");

endmodule

bind wallace_mul_top mul_asserts i_mul_asserts (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .done  (done)
);

`default_nettype wire

/* bench/tb_wallace_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wallace_mul;

    localparam int TIMEOUT = 100;
    localparam int LAT     = mul_pkg::MUL_LATENCY;

    logic           clk;
    logic           rst;
    logic           start;
    mul_pkg::op_t   a;
    mul_pkg::op_t   b;
    mul_pkg::prod_t product;
    logic           done;

    mul_pkg::prod_t expected_q[$];
    mul_pkg::prod_t last_product;
    int             done_count;
    int             start_count;
    int             error_count;
    int             timeout_count;

    wallace_mul_top i_wallace_mul_top (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .a       (a),
        .b       (b),
        .product (product),
        .done    (done)
    );

    always #20 clk = ~clk;

    task automatic check_product(input mul_pkg::prod_t got, input mul_pkg::prod_t exp,
                                 input string what);
        if (got !== exp) begin
            $display("Fail at time %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail at time %0t: %s got %0d expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    // called on a falling edge and returns one falling edge later with start low
    task automatic drive_op(input mul_pkg::op_t x, input mul_pkg::op_t y);
        start = 1'b1;
        a     = x;
        b     = y;
        expected_q.push_back(mul_pkg::prod_t'(x) * mul_pkg::prod_t'(y));
        start_count++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done_count(input int target, input string what);
        int n;
        n = 0;
        while (done_count < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (done_count < target) begin
            $display("Timeout at time %0t: done never arrived for %s", $time, what);
            timeout_count++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expected_q.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (expected_q.size() != 0) begin
            $display("Timeout at time %0t: %0d products never came out", $time,
                     expected_q.size());
            timeout_count++;
        end
    endtask

    task automatic single_op(input mul_pkg::op_t x, input mul_pkg::op_t y, input string what);
        int target;
        target = done_count + 1;
        drive_op(x, y);
        wait_done_count(target, what);
        repeat (2) @(negedge clk);
    endtask

    task automatic test_reset_idle();
        int highs;
        highs = 0;
        repeat (20) begin
            @(negedge clk);
            if (done) begin
                highs++;
            end
            check_product(product, '0, "product while idle");
        end
        check_count(highs, 0, "done pulses while idle");
    endtask

    task automatic test_corners();
        single_op(32'd0, 32'hdead_beef, "zero times x");
        single_op(32'h1234_5678, 32'd0, "x times zero");
        single_op(32'd1, 32'hcafe_f00d, "one times x");
        single_op(32'h8765_4321, 32'd1, "x times one");
        single_op('1, '1, "all ones squared");
        for (int k = 0; k < 32; k += 5) begin
            single_op(mul_pkg::op_t'(1) << k, mul_pkg::op_t'(1) << (31 - k), "powers of two");
        end
        single_op(32'h8000_0000, 32'h8000_0000, "top bit squared");
        single_op(32'h0001_0000, 32'hffff_ffff, "power of two times all ones");
    endtask

    task automatic test_latency();
        int n;
        int base;
        base = done_count;
        drive_op(32'h0000_abcd, 32'h0012_3456);
        // one falling edge has passed since start was driven
        n = 1;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("Timeout at time %0t: done never rose in the latency test", $time);
            timeout_count++;
        end else begin
            check_count(n, LAT, "edges from start to done");
        end
        repeat (10) @(negedge clk);
        check_count(done_count - base, 1, "done pulses for one start");
    endtask

    task automatic test_back_to_back();
        int run;
        int n;
        run = 0;
        n   = 0;
        fork
            begin
                repeat (50) drive_op($urandom, $urandom);
            end
            begin
                while (!done && n < TIMEOUT) begin
                    @(negedge clk);
                    n++;
                end
                while (done && run < 60) begin
                    run++;
                    @(negedge clk);
                end
            end
        join
        if (run == 0) begin
            $display("Timeout at time %0t: no done in the back-to-back burst", $time);
            timeout_count++;
        end else begin
            check_count(run, 50, "consecutive done cycles");
        end
        wait_drain();
    endtask

    task automatic test_random_gaps();
        int gap;
        for (int i = 0; i < 100; i++) begin
            drive_op($urandom, $urandom);
            gap = $urandom_range(4, 0);
            repeat (gap) @(negedge clk);
        end
        wait_drain();
    endtask

    // output monitor sees values registered on the previous edge
    initial begin
        mul_pkg::prod_t exp_val;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (done) begin
                    if (expected_q.size() == 0) begin
                        $display("Error at time %0t: done pulse with no operation pending",
                                 $time);
                        error_count++;
                    end else begin
                        exp_val = expected_q.pop_front();
                        check_product(product, exp_val, "product");
                        last_product = exp_val;
                    end
                    done_count++;
                end else begin
                    check_product(product, last_product, "product held between pulses");
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h1492));
        clk           = 1'b0;
        rst           = 1'b1;
        start         = 1'b0;
        a             = '0;
        b             = '0;
        last_product  = '0;
        done_count    = 0;
        start_count   = 0;
        error_count   = 0;
        timeout_count = 0;

        repeat (8) @(negedge clk);
        rst = 1'b0;

        test_reset_idle();
        test_corners();
        test_latency();
        test_back_to_back();
        test_random_gaps();
        wait_drain();
        check_count(done_count, start_count, "done pulses against starts");

        $display("errors: %0d value, %0d timeout", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/mul_pkg.sv
src/mul_operand_latch.sv
src/pp_compress.sv
src/csa_reduce_stage.sv
src/final_adder.sv
src/wallace_mul_top.sv
bench/mul_asserts.sv
bench/tb_wallace_mul.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_wallace_mul \
    -f compile.f \
    -o sim_wallace_mul

./obj_dir/sim_wallace_mul | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
